/* common/ocr_pkg.sv */
package ocr_pkg;

    // ==================== frame geometry
    localparam int NUM_SEG   = 5;
    localparam int NUM_FEAT  = 8;
    localparam int FRAME_LEN = NUM_SEG * NUM_FEAT;   // index = seg * 8 + feat.

    // window p spans segments p .. p+2.
    localparam int WIN_SEG  = 3;
    localparam int NUM_POS  = 3;
    localparam int NUM_TAPS = NUM_FEAT * WIN_SEG;    // tap = feat * 3 + offset.

    // ==================== network size
    localparam int NUM_CH    = 10;
    localparam int NUM_FEATS = NUM_CH * NUM_POS;     // index = ch * 3 + pos.
    localparam int NUM_CLASS = 27;
    localparam int TOP_N     = 3;

    // fixed point, q.12.
    localparam int FRAC_BITS = 12;

    // ==================== coefficient map
    localparam int CONV_W_BASE = 0;
    localparam int CONV_B_BASE = CONV_W_BASE + NUM_CH * NUM_TAPS;
    localparam int FC_W_BASE   = CONV_B_BASE + NUM_CH;
    localparam int FC_B_BASE   = FC_W_BASE + NUM_CLASS * NUM_FEATS;
    localparam int NUM_COEF    = FC_B_BASE + NUM_CLASS;

    // ==================== scalar types
    typedef logic signed [15:0] sample_t;
    typedef logic signed [15:0] coef_t;
    typedef logic signed [23:0] feat_t;
    typedef logic signed [31:0] score_t;
    typedef logic        [4:0]  class_t;       // 0 to 26.
    typedef logic        [10:0] coef_addr_t;   // 0 to 1086.

endpackage

/* src/frame_sequencer.sv */
`timescale 1ns/1ps

module frame_sequencer #(
    parameter int NUM_COEF  = ocr_pkg::NUM_COEF,
    parameter int FRAME_LEN = ocr_pkg::FRAME_LEN
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_req,
    input  logic                i_is_coef,
    input  ocr_pkg::sample_t    i_data,
    input  logic                i_ch_empty,
    output logic                o_ack,
    output logic                o_coef_we,
    output ocr_pkg::coef_addr_t o_coef_addr,
    output ocr_pkg::coef_t      o_coef_data,
    output logic                o_tap_valid,
    output logic                o_tap_last,
    output logic [4:0]          o_tap_idx,
    output ocr_pkg::sample_t    o_tap_sample
);
    import ocr_pkg::*;

    localparam int IDX_W = $clog2(FRAME_LEN);

    logic             take;
    logic             frame_full;   // set by the last sample.
    logic             scanning;
    logic [IDX_W-1:0] wr_idx;
    logic [IDX_W-1:0] rd_idx;
    coef_addr_t       addr_cnt;
    logic [1:0]       off_cnt;
    logic [2:0]       feat_cnt;
    logic [1:0]       pos_cnt;
    sample_t          frame_mem [FRAME_LEN];

    assign take = i_req && !o_ack && !frame_full;

    // ==================== input handshake
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ack      <= 1'b0;
            o_coef_we  <= 1'b0;
            addr_cnt   <= '0;
            wr_idx     <= '0;
            frame_full <= 1'b0;
            scanning   <= 1'b0;
            off_cnt    <= '0;
            feat_cnt   <= '0;
            pos_cnt    <= '0;
        end else begin
            if (take) begin
                o_ack <= 1'b1;
            end else if (!i_req) begin
                o_ack <= 1'b0;
            end
            o_coef_we <= take && i_is_coef;
            if (take && i_is_coef) begin
                addr_cnt <= (addr_cnt == coef_addr_t'(NUM_COEF - 1)) ? '0 : addr_cnt + 1'b1;
            end else if (take) begin
                addr_cnt <= '0;   // next load starts over.
                if (wr_idx == IDX_W'(FRAME_LEN - 1)) begin
                    wr_idx     <= '0;
                    frame_full <= 1'b1;
                end else begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end

            // scan order is position, feature, segment offset.
            if (scanning) begin
                if (off_cnt == 2'(WIN_SEG - 1)) begin
                    off_cnt <= '0;
                    if (feat_cnt == 3'(NUM_FEAT - 1)) begin
                        feat_cnt <= '0;
                        if (pos_cnt == 2'(NUM_POS - 1)) begin
                            pos_cnt    <= '0;
                            scanning   <= 1'b0;
                            frame_full <= 1'b0;
                        end else begin
                            pos_cnt <= pos_cnt + 1'b1;
                        end
                    end else begin
                        feat_cnt <= feat_cnt + 1'b1;
                    end
                end else begin
                    off_cnt <= off_cnt + 1'b1;
                end
            end else if (frame_full && i_ch_empty) begin
                scanning <= 1'b1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            o_coef_addr <= addr_cnt;
            o_coef_data <= i_data;
        end
        if (take && !i_is_coef) begin
            frame_mem[wr_idx] <= i_data;
        end
    end

    // ==================== tap stream
    assign rd_idx       = IDX_W'((pos_cnt + off_cnt) * NUM_FEAT + feat_cnt);
    assign o_tap_valid  = scanning;
    assign o_tap_idx    = 5'(feat_cnt * WIN_SEG + off_cnt);
    assign o_tap_last   = (feat_cnt == 3'(NUM_FEAT - 1)) && (off_cnt == 2'(WIN_SEG - 1));
    assign o_tap_sample = frame_mem[rd_idx];

    // the frame buffer must not change under a running scan.
    a_no_ack_in_scan : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        scanning |-> !$rose(o_ack));

endmodule

/* conv/conv_channel.sv */
`timescale 1ns/1ps

module conv_channel #(
    parameter int CH_INDEX = 0
) (
    input  logic                i_clk,
    input  logic                i_rst_n,
    input  logic                i_coef_we,
    input  ocr_pkg::coef_addr_t i_coef_addr,
    input  ocr_pkg::coef_t      i_coef_data,
    input  logic                i_tap_valid,
    input  logic                i_tap_last,
    input  logic [4:0]          i_tap_idx,
    input  ocr_pkg::sample_t    i_tap_sample,
    input  logic                i_take,
    output ocr_pkg::feat_t      o_feat0,
    output ocr_pkg::feat_t      o_feat1,
    output ocr_pkg::feat_t      o_feat2,
    output logic                o_feat_valid,
    output logic                o_empty
);
    import ocr_pkg::*;

    localparam int W_BASE = CONV_W_BASE + CH_INDEX * NUM_TAPS;
    localparam int B_ADDR = CONV_B_BASE + CH_INDEX;

    coef_t              kern [NUM_TAPS];
    coef_t              bias_r;
    coef_addr_t         w_off;
    logic signed [31:0] prod;
    logic signed [39:0] acc;
    logic signed [39:0] sum;
    logic signed [39:0] shifted;
    feat_t              sat;
    feat_t              feat_r [NUM_POS];
    logic [1:0]         pos_cnt;

    // ==================== coefficient store
    assign w_off = i_coef_addr - coef_addr_t'(W_BASE);   // wraps high below the base.

    always_ff @(posedge i_clk) begin
        if (i_coef_we && w_off < coef_addr_t'(NUM_TAPS)) begin
            kern[w_off[4:0]] <= i_coef_data;
        end
        if (i_coef_we && i_coef_addr == coef_addr_t'(B_ADDR)) begin
            bias_r <= i_coef_data;
        end
    end

    // ==================== window arithmetic
    assign prod    = i_tap_sample * kern[i_tap_idx];
    assign sum     = acc + 40'(prod) + (40'(bias_r) <<< FRAC_BITS);
    assign shifted = sum >>> FRAC_BITS;

    always_comb begin
        if (shifted > 40'sh00_007f_ffff) begin
            sat = 24'sh7f_ffff;
        end else if (shifted < -40'sh00_0080_0000) begin
            sat = 24'sh80_0000;
        end else begin
            sat = shifted[23:0];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_tap_valid) begin
            acc <= i_tap_last ? '0 : acc + 40'(prod);
        end else if (!o_feat_valid) begin
            acc <= '0;
        end
        if (i_tap_valid && i_tap_last) begin
            feat_r[pos_cnt] <= sat;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pos_cnt      <= '0;
            o_feat_valid <= 1'b0;
        end else begin
            if (i_tap_valid && i_tap_last) begin
                if (pos_cnt == 2'(NUM_POS - 1)) begin
                    pos_cnt      <= '0;
                    o_feat_valid <= 1'b1;   // all three windows done.
                end else begin
                    pos_cnt <= pos_cnt + 1'b1;
                end
            end else if (i_take) begin
                o_feat_valid <= 1'b0;
            end
        end
    end

    assign o_feat0 = feat_r[0];
    assign o_feat1 = feat_r[1];
    assign o_feat2 = feat_r[2];
    assign o_empty = !o_feat_valid;

    // held results are only released by the classifier.
    a_no_tap_while_held : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_feat_valid |-> !i_tap_valid);

endmodule

/* src/classifier.sv */
`timescale 1ns/1ps

module classifier #(
    parameter int NUM_FEATS = ocr_pkg::NUM_FEATS,
    parameter int NUM_CLASS = ocr_pkg::NUM_CLASS
) (
    input  logic                           i_clk,
    input  logic                           i_rst_n,
    input  logic                           i_coef_we,
    input  ocr_pkg::coef_addr_t            i_coef_addr,
    input  ocr_pkg::coef_t                 i_coef_data,
    input  logic                           i_feats_valid,
    input  ocr_pkg::feat_t [NUM_FEATS-1:0] i_feats,
    input  logic                           i_res_ack,
    output logic                           o_take,
    output logic                           o_res_req,
    output ocr_pkg::class_t                o_class0,
    output ocr_pkg::class_t                o_class1,
    output ocr_pkg::class_t                o_class2,
    output ocr_pkg::score_t                o_score0,
    output ocr_pkg::score_t                o_score1,
    output ocr_pkg::score_t                o_score2
);
    import ocr_pkg::*;

    localparam int NUM_W   = NUM_CLASS * NUM_FEATS;
    localparam int W_IDX_W = $clog2(NUM_W);
    localparam int F_IDX_W = $clog2(NUM_FEATS);

    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_MAC     = 3'd1;
    localparam logic [2:0] S_RANK    = 3'd2;
    localparam logic [2:0] S_OFFER   = 3'd3;
    localparam logic [2:0] S_RELEASE = 3'd4;

    logic [2:0]         state;
    coef_t              fc_w [NUM_W];
    coef_t              fc_b [NUM_CLASS];
    coef_addr_t         fw_off;
    coef_addr_t         fb_off;
    feat_t              feats_r [NUM_FEATS];
    logic [W_IDX_W-1:0] w_idx;
    logic [F_IDX_W-1:0] f_idx;
    class_t             cls;
    logic signed [39:0] prod;
    logic signed [47:0] acc;
    logic signed [47:0] shifted;
    score_t             score;
    logic [TOP_N-1:0]   rank_v;
    logic [TOP_N-1:0]   beat;
    class_t             rank_c [TOP_N];
    score_t             rank_s [TOP_N];

    // ==================== weight store
    assign fw_off = i_coef_addr - coef_addr_t'(FC_W_BASE);
    assign fb_off = i_coef_addr - coef_addr_t'(FC_B_BASE);

    always_ff @(posedge i_clk) begin
        if (i_coef_we && fw_off < coef_addr_t'(NUM_W)) begin
            fc_w[fw_off[W_IDX_W-1:0]] <= i_coef_data;
        end
        if (i_coef_we && fb_off < coef_addr_t'(NUM_CLASS)) begin
            fc_b[fb_off[4:0]] <= i_coef_data;
        end
    end

    // ==================== score and rank
    assign o_take  = (state == S_IDLE) && i_feats_valid;
    assign prod    = feats_r[f_idx] * fc_w[w_idx];
    assign shifted = (acc + (48'(fc_b[cls]) <<< FRAC_BITS)) >>> FRAC_BITS;

    always_comb begin
        if (shifted > 48'sh0000_7fff_ffff) begin
            score = 32'sh7fff_ffff;
        end else if (shifted < -48'sh0000_8000_0000) begin
            score = 32'sh8000_0000;
        end else begin
            score = shifted[31:0];
        end
        // strict compare keeps the earlier, lower class ahead on a tie.
        for (int k = 0; k < TOP_N; k++) begin
            beat[k] = !rank_v[k] || (score > rank_s[k]);
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            w_idx     <= '0;
            f_idx     <= '0;
            cls       <= '0;
            rank_v    <= '0;
            o_res_req <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (o_take) begin
                        state  <= S_MAC;
                        w_idx  <= '0;
                        f_idx  <= '0;
                        cls    <= '0;
                        rank_v <= '0;
                    end
                end
                S_MAC: begin
                    w_idx <= w_idx + 1'b1;
                    if (f_idx == F_IDX_W'(NUM_FEATS - 1)) begin
                        f_idx <= '0;
                        state <= S_RANK;
                    end else begin
                        f_idx <= f_idx + 1'b1;
                    end
                end
                S_RANK: begin
                    rank_v <= {rank_v[TOP_N-2:0], 1'b1};   // one more entry filled.
                    if (cls == class_t'(NUM_CLASS - 1)) begin
                        state     <= S_OFFER;
                        o_res_req <= 1'b1;
                    end else begin
                        cls   <= cls + 1'b1;
                        state <= S_MAC;
                    end
                end
                S_OFFER: begin
                    if (i_res_ack) begin
                        o_res_req <= 1'b0;
                        state     <= S_RELEASE;
                    end
                end
                default: begin
                    if (!i_res_ack) begin
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (o_take) begin
            for (int i = 0; i < NUM_FEATS; i++) begin
                feats_r[i] <= i_feats[i];
            end
            acc <= '0;
        end else if (state == S_MAC) begin
            acc <= acc + 48'(prod);
        end else if (state == S_RANK) begin
            acc <= '0;
            if (beat[0]) begin
                rank_c[2] <= rank_c[1];
                rank_s[2] <= rank_s[1];
                rank_c[1] <= rank_c[0];
                rank_s[1] <= rank_s[0];
                rank_c[0] <= cls;
                rank_s[0] <= score;
            end else if (beat[1]) begin
                rank_c[2] <= rank_c[1];
                rank_s[2] <= rank_s[1];
                rank_c[1] <= cls;
                rank_s[1] <= score;
            end else if (beat[2]) begin
                rank_c[2] <= cls;
                rank_s[2] <= score;
            end
        end
    end

    assign o_class0 = rank_c[0];
    assign o_class1 = rank_c[1];
    assign o_class2 = rank_c[2];
    assign o_score0 = rank_s[0];
    assign o_score1 = rank_s[1];
    assign o_score2 = rank_s[2];

    // result port holds steady through the handshake.
    a_res_stable : assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_res_req && !i_res_ack |=> o_res_req
            && $stable({o_class0, o_class1, o_class2, o_score0, o_score1, o_score2}));

endmodule

/* src/ocr_top.sv */
`timescale 1ns/1ps

module ocr_top (
    input  logic             i_clk,
    input  logic             i_rst_n,
    input  logic             i_req,
    input  logic             i_is_coef,
    input  ocr_pkg::sample_t i_data,
    output logic             o_ack,
    output logic             o_res_req,
    input  logic             i_res_ack,
    output ocr_pkg::class_t  o_class0,
    output ocr_pkg::class_t  o_class1,
    output ocr_pkg::class_t  o_class2,
    output ocr_pkg::score_t  o_score0,
    output ocr_pkg::score_t  o_score1,
    output ocr_pkg::score_t  o_score2
);
    import ocr_pkg::*;

    logic                  coef_we;
    coef_addr_t            coef_addr;
    coef_t                 coef_data;
    logic                  tap_valid;
    logic                  tap_last;
    logic [4:0]            tap_idx;
    sample_t               tap_sample;
    logic [NUM_CH-1:0]     ch_valid;
    logic [NUM_CH-1:0]     ch_empty;
    feat_t [NUM_FEATS-1:0] feats;
    logic                  take;

    // ==================== input side
    frame_sequencer #(
        .NUM_COEF (NUM_COEF),
        .FRAME_LEN(FRAME_LEN)
    ) u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req       (i_req),
        .i_is_coef   (i_is_coef),
        .i_data      (i_data),
        .i_ch_empty  (&ch_empty),
        .o_ack       (o_ack),
        .o_coef_we   (coef_we),
        .o_coef_addr (coef_addr),
        .o_coef_data (coef_data),
        .o_tap_valid (tap_valid),
        .o_tap_last  (tap_last),
        .o_tap_idx   (tap_idx),
        .o_tap_sample(tap_sample)
    );

    // ==================== convolution bank
    for (genvar c = 0; c < NUM_CH; c++) begin : g_ch
        conv_channel #(
            .CH_INDEX(c)
        ) u_ch (
            .i_clk       (i_clk),
            .i_rst_n     (i_rst_n),
            .i_coef_we   (coef_we),
            .i_coef_addr (coef_addr),
            .i_coef_data (coef_data),
            .i_tap_valid (tap_valid),
            .i_tap_last  (tap_last),
            .i_tap_idx   (tap_idx),
            .i_tap_sample(tap_sample),
            .i_take      (take),
            .o_feat0     (feats[c*NUM_POS]),
            .o_feat1     (feats[c*NUM_POS+1]),
            .o_feat2     (feats[c*NUM_POS+2]),
            .o_feat_valid(ch_valid[c]),
            .o_empty     (ch_empty[c])
        );
    end

    // ==================== output side
    classifier #(
        .NUM_FEATS(NUM_FEATS),
        .NUM_CLASS(NUM_CLASS)
    ) u_cls (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_coef_we    (coef_we),
        .i_coef_addr  (coef_addr),
        .i_coef_data  (coef_data),
        .i_feats_valid(&ch_valid),   // every channel finished.
        .i_feats      (feats),
        .i_res_ack    (i_res_ack),
        .o_take       (take),
        .o_res_req    (o_res_req),
        .o_class0     (o_class0),
        .o_class1     (o_class1),
        .o_class2     (o_class2),
        .o_score0     (o_score0),
        .o_score1     (o_score1),
        .o_score2     (o_score2)
    );

endmodule

/* tb/ocr_model.svh */
`ifndef OCR_MODEL_SVH
`define OCR_MODEL_SVH

// ==================== model state
int     coef_mem  [NUM_COEF];    // same order as the load.
int     frame_mem [FRAME_LEN];
longint feat_mdl  [NUM_FEATS];
int     exp_class [$];           // three per frame, best first.
longint exp_score [$];

function automatic longint saturate(input longint v, input int bits);
    longint hi;
    longint lo;
    hi = (longint'(1) <<< (bits - 1)) - 1;
    lo = -(longint'(1) <<< (bits - 1));
    if (v > hi) begin
        return hi;
    end
    if (v < lo) begin
        return lo;
    end
    return v;
endfunction

// window pos covers segments pos to pos+2.
function automatic longint conv_feature(input int ch, input int pos);
    longint acc;
    acc = 0;
    for (int f = 0; f < NUM_FEAT; f++) begin
        for (int o = 0; o < WIN_SEG; o++) begin
            acc += longint'(frame_mem[(pos + o) * NUM_FEAT + f])
                 * longint'(coef_mem[CONV_W_BASE + ch * NUM_TAPS + f * WIN_SEG + o]);
        end
    end
    acc += longint'(coef_mem[CONV_B_BASE + ch]) <<< FRAC_BITS;
    return saturate(acc >>> FRAC_BITS, $bits(feat_t));
endfunction

function automatic longint class_score(input int cls);
    longint acc;
    acc = 0;
    for (int i = 0; i < NUM_FEATS; i++) begin
        acc += feat_mdl[i] * longint'(coef_mem[FC_W_BASE + cls * NUM_FEATS + i]);
    end
    acc += longint'(coef_mem[FC_B_BASE + cls]) <<< FRAC_BITS;
    return saturate(acc >>> FRAC_BITS, $bits(score_t));
endfunction

// ==================== ranking
function automatic void predict_frame();
    int     top_c [TOP_N];
    longint top_s [TOP_N];
    int     n;
    int     k;
    longint s;
    n = 0;
    for (int ch = 0; ch < NUM_CH; ch++) begin
        for (int p = 0; p < NUM_POS; p++) begin
            feat_mdl[ch * NUM_POS + p] = conv_feature(ch, p);
        end
    end
    for (int j = 0; j < NUM_CLASS; j++) begin
        s = class_score(j);
        k = 0;
        while (k < n && top_s[k] >= s) begin
            k++;   // equal score stays behind the lower class.
        end
        if (k < TOP_N) begin
            for (int m = TOP_N - 1; m > k; m--) begin
                top_c[m] = top_c[m - 1];
                top_s[m] = top_s[m - 1];
            end
            top_c[k] = j;
            top_s[k] = s;
            if (n < TOP_N) begin
                n++;
            end
        end
    end
    for (int r = 0; r < TOP_N; r++) begin
        exp_class.push_back(top_c[r]);
        exp_score.push_back(top_s[r]);
    end
endfunction

`endif

/* tb/tb_ocr.sv */
`timescale 1ns/1ps

module tb_ocr;
    import ocr_pkg::*;

    localparam int          CLK_PERIOD     = 100;
    localparam logic [31:0] SEED           = 32'h07d8b728;
    localparam int          NUM_LOADS      = 4;
    localparam int          NUM_FRAMES     = 13;
    localparam int          WORD_CYCLES    = 4;
    localparam int          FRAME_CYCLES   = NUM_POS * NUM_TAPS + NUM_CLASS * (NUM_FEATS + 1) + 32;
    localparam int          TIMEOUT_CYCLES = 16 + NUM_LOADS * NUM_COEF * WORD_CYCLES
        + NUM_FRAMES * (FRAME_LEN * WORD_CYCLES + FRAME_CYCLES) + FRAME_CYCLES + 1000;

    logic        i_clk = 1'b0;
    logic        i_rst_n;
    logic        i_req;
    logic        i_is_coef;
    sample_t     i_data;
    logic        o_ack;
    logic        o_res_req;
    logic        i_res_ack;
    class_t      o_class0;
    class_t      o_class1;
    class_t      o_class2;
    score_t      o_score0;
    score_t      o_score1;
    score_t      o_score2;
    logic [31:0] rng_stim;
    logic [31:0] rng_ack;
    int          frames_sent;
    int          results_seen;
    logic [31:0] cur_c [TOP_N];
    logic [31:0] cur_s [TOP_N];

    `include "ocr_model.svh"

    ocr_top i_dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_req    (i_req),
        .i_is_coef(i_is_coef),
        .i_data   (i_data),
        .o_ack    (o_ack),
        .o_res_req(o_res_req),
        .i_res_ack(i_res_ack),
        .o_class0 (o_class0),
        .o_class1 (o_class1),
        .o_class2 (o_class2),
        .o_score0 (o_score0),
        .o_score1 (o_score1),
        .o_score2 (o_score2)
    );

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    // ==================== helpers
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int random_word();
        rng_stim = xorshift32(rng_stim);
        return int'($signed(rng_stim[15:0]));
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("CHECKS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            abort_run($sformatf("[ERROR] %s: expected 0x%08h, got 0x%08h", name, exp, got));
        end
    endtask

    task automatic read_outputs();
        cur_c[0] = 32'(o_class0);
        cur_c[1] = 32'(o_class1);
        cur_c[2] = 32'(o_class2);
        cur_s[0] = o_score0;
        cur_s[1] = o_score1;
        cur_s[2] = o_score2;
    endtask

    // one four-phase word on the input port.
    task automatic send_word(input logic is_coef, input int value);
        @(posedge i_clk);
        #1;
        i_req     = 1'b1;
        i_is_coef = is_coef;
        i_data    = sample_t'(value);
        do begin
            @(posedge i_clk);
            #1;
        end while (!o_ack);
        i_req = 1'b0;
        do begin
            @(posedge i_clk);
            #1;
        end while (o_ack);
    endtask

    task automatic load_coefs();
        for (int a = 0; a < NUM_COEF; a++) begin
            send_word(1'b1, coef_mem[a]);
        end
    endtask

    task automatic send_frame();
        predict_frame();
        frames_sent++;
        for (int i = 0; i < FRAME_LEN; i++) begin
            send_word(1'b0, frame_mem[i]);
        end
    endtask

    task automatic wait_drained();
        while (results_seen != frames_sent) begin
            @(posedge i_clk);
            #1;
        end
    endtask

    task automatic set_extreme_coefs();
        for (int c = 0; c < NUM_CH; c++) begin
            for (int k = 0; k < NUM_TAPS; k++) begin
                coef_mem[CONV_W_BASE + c * NUM_TAPS + k] = (c % 2 == 0) ? -32768 : 32767;
            end
            coef_mem[CONV_B_BASE + c] = (c % 2 == 0) ? 32767 : -32768;
        end
        for (int j = 0; j < NUM_CLASS; j++) begin
            for (int i = 0; i < NUM_FEATS; i++) begin
                coef_mem[FC_W_BASE + j * NUM_FEATS + i] = ((i + j) % 2 == 0) ? 32767 : -32768;
            end
            coef_mem[FC_B_BASE + j] = 32767;
        end
    endtask

    // ==================== result port
    initial begin : result_sink
        logic [31:0] held_c [TOP_N];
        logic [31:0] held_s [TOP_N];
        int          delay;
        wait (i_rst_n === 1'b1);
        forever begin
            @(posedge i_clk);
            #1;
            if (o_res_req) begin
                read_outputs();
                held_c = cur_c;
                held_s = cur_s;
                rng_ack = xorshift32(rng_ack);
                delay = int'(rng_ack % 24);
                repeat (delay) begin
                    @(posedge i_clk);
                    #1;
                    assert (o_res_req) else abort_run("o_res_req dropped before i_res_ack rose");
                    read_outputs();
                    for (int k = 0; k < TOP_N; k++) begin
                        check_value($sformatf("o_class%0d", k), cur_c[k], held_c[k]);
                        check_value($sformatf("o_score%0d", k), cur_s[k], held_s[k]);
                    end
                end
                assert (exp_class.size() >= TOP_N) else begin
                    abort_run("a result was offered with no frame outstanding");
                end
                for (int k = 0; k < TOP_N; k++) begin
                    check_value($sformatf("o_class%0d", k), held_c[k], 32'(exp_class.pop_front()));
                    check_value($sformatf("o_score%0d", k), held_s[k], 32'(exp_score.pop_front()));
                end
                i_res_ack = 1'b1;
                do begin
                    @(posedge i_clk);
                    #1;
                end while (o_res_req);
                i_res_ack = 1'b0;
                results_seen++;
            end
        end
    end

    initial begin : watchdog
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        abort_run($sformatf("timeout: the run did not finish in %0d cycles", TIMEOUT_CYCLES));
    end

    // ==================== stimulus
    initial begin : stimulus
        i_rst_n      = 1'b0;
        i_req        = 1'b0;
        i_is_coef    = 1'b0;
        i_data       = '0;
        i_res_ack    = 1'b0;
        rng_stim     = SEED;
        rng_ack      = SEED ^ 32'h5bd1e995;   // own stream for ack delays.
        frames_sent  = 0;
        results_seen = 0;
        repeat (16) @(posedge i_clk);
        #1;
        i_rst_n = 1'b1;
        @(posedge i_clk);
        #1;
        check_value("o_ack", 32'(o_ack), 32'h0);
        check_value("o_res_req", 32'(o_res_req), 32'h0);

        // random set, frames overlap the slow result reader.
        foreach (coef_mem[a]) coef_mem[a] = random_word();
        load_coefs();
        repeat (8) begin
            foreach (frame_mem[i]) frame_mem[i] = random_word();
            send_frame();
        end
        wait_drained();

        // largest magnitudes on samples and weights.
        set_extreme_coefs();
        load_coefs();
        foreach (frame_mem[i]) frame_mem[i] = -32768;
        send_frame();
        wait_drained();

        // zero frame, scores fall back to the class biases with ties.
        foreach (coef_mem[a]) coef_mem[a] = random_word();
        for (int c = 0; c < NUM_CH; c++) begin
            coef_mem[CONV_B_BASE + c] = 0;
        end
        for (int j = 0; j < NUM_CLASS; j++) begin
            coef_mem[FC_B_BASE + j] = -(j % 5) - 1;
        end
        load_coefs();
        foreach (frame_mem[i]) frame_mem[i] = 0;
        send_frame();
        wait_drained();

        // fresh set, same zero frame first.
        foreach (coef_mem[a]) coef_mem[a] = random_word();
        load_coefs();
        send_frame();
        repeat (2) begin
            foreach (frame_mem[i]) frame_mem[i] = random_word();
            send_frame();
        end
        wait_drained();

        // no result may follow once every frame is answered.
        repeat (FRAME_CYCLES) begin
            @(posedge i_clk);
            #1;
            assert (!o_res_req) else abort_run("o_res_req rose after the last frame was answered");
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

/* list.f */
+incdir+tb
common/ocr_pkg.sv
src/frame_sequencer.sv
conv/conv_channel.sv
src/classifier.sv
src/ocr_top.sv
tb/tb_ocr.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -j 0
TOP       ?= tb_ocr
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
